//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = sys_core_tb
FILELIST = build.f
LOG      = sim.log
OBJ_DIR  = obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^TEST OK$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- build.f
hw/sys_core_pkg.sv
hw/hps_cmd_decoder.sv
hw/audio_mix_channel.sv
hw/sync_polarity_fix.sv
hw/video_sync_out.sv
hw/sys_core_top.sv
dv/sys_core_assert.sv
dv/sys_core_tb.sv

//--- dv/sys_core_assert.sv
`timescale 1ns/1ps

module sys_core_assert (
	input logic                  clk_sys,
	input logic                  resetd,
	input sys_core_pkg::att_t    i_att,
	input sys_core_pkg::sample_t o_sample
);

	// Output cleared right after a reset cycle
	property p_reset_zero;
		@(posedge clk_sys) resetd |=> (o_sample == '0);
	endproperty

	// Five mute cycles flush the attenuation and clamp stages
	property p_mute_zero;
		@(posedge clk_sys) disable iff (resetd) (i_att[4])[*5] |-> (o_sample == '0);
	endproperty

	a_reset_zero: assert property (p_reset_zero) else $error("audio output not zero after reset");
	a_mute_zero: assert property (p_mute_zero) else $error("audio output not zero while muted");

endmodule

bind audio_mix_channel sys_core_assert u_assert (
	.clk_sys  (clk_sys),
	.resetd   (resetd),
	.i_att    (i_att),
	.o_sample (o_sample)
);

//--- dv/sys_core_golden.txt
# test nwords w0 w1 w2 w3 core_l core_r linux_l linux_r signed mix
#  sync_low sync_high exp_l exp_r exp_hs exp_vs (sync lengths decimal, hs/vs bits A,B,C)
1 0 0000 0000 0000 0000 0000 0000 0000 0000 1 0 0 0 0000 0000 1 1
2 0 0000 0000 0000 0000 1000 FF00 0234 0100 1 0 0 0 1234 0000 1 1
2 0 0000 0000 0000 0000 7000 9000 2000 A000 1 0 0 0 7FFF 8000 1 1
3 0 0000 0000 0000 0000 8000 FFFE 0010 0001 0 0 0 0 4010 7FFF 1 1
3 0 0000 0000 0000 0000 0002 0000 0000 FFFF 0 0 0 0 0001 FFFF 1 1
4 0 0000 0000 0000 0000 0800 0400 0000 0000 1 1 0 0 0780 0480 1 1
4 0 0000 0000 0000 0000 0800 0400 0000 0000 1 2 0 0 0700 0500 1 1
4 0 0000 0000 0000 0000 0003 FFFB 0000 0000 1 3 0 0 FFFE FFFE 1 1
5 2 0026 0002 0000 0000 1000 F000 0000 0000 1 0 0 0 0400 FC00 1 1
5 2 0026 0010 0000 0000 1000 F000 0000 0000 1 0 0 0 0000 0000 1 1
5 2 0055 0001 0000 0000 1000 F000 0000 0000 1 0 0 0 0000 0000 1 1
5 4 0055 0002 0026 0003 1000 F000 0000 0000 1 0 0 0 0200 FE00 1 1
6 2 0026 0000 0000 0000 0000 0000 0000 0000 1 0 6 14 0000 0000 2 4
7 2 0001 0008 0000 0000 0000 0000 0000 0000 1 0 6 14 0000 0000 1 7

//--- dv/sys_core_tb.sv
`timescale 1ns/1ps

module sys_core_tb;
	import sys_core_pkg::*;

	logic      clk_sys;
	logic      resetd;
	logic      i_io_uio;
	logic      i_io_clk;
	io_word_t  i_io_din;
	sample_t   i_core_l;
	sample_t   i_core_r;
	sample_t   i_linux_l;
	sample_t   i_linux_r;
	logic      i_audio_signed;
	mix_mode_t i_audio_mix;
	logic      i_hs;
	logic      i_vs;
	sample_t   o_audio_l;
	sample_t   o_audio_r;
	logic      o_vga_hs;
	logic      o_vga_vs;

	int          errors = 0;
	int          checks = 0;
	logic [31:0] lfsr = 32'h44740643;
	logic        sync_on = 1'b0;
	int          sync_l = 1;
	int          sync_p = 2;
	int          vpos = 0;

	sys_core_top #(.SYNC_CNT_W(12)) UUT (.*);

	always #4 clk_sys = ~clk_sys;

	// Test sync source with VS phases four times the HS phases
	always @(posedge clk_sys) begin
		if (sync_on) begin
			i_hs <= ((vpos % sync_p) >= sync_l);
			i_vs <= (vpos >= 4 * sync_l);
			vpos <= (vpos == 4 * sync_p - 1) ? 0 : vpos + 1;
		end
	end

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	function automatic logic [15:0] random_bits(input int n);
		logic [15:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[14:0], lfsr[0]};
			lfsr = lfsr_next(lfsr);
		end
		return v;
	endfunction

	task automatic check_value(input string what, input logic [15:0] got, input logic [15:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("MISMATCH t=%0t %s: got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("TEST FAILED");
		$finish;
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge clk_sys);
	endtask

	// One command and its data word, then select dropped
	task automatic send_pair(input io_word_t cmd, input io_word_t data);
		i_io_uio <= 1'b1;
		wait_cycles(2);
		i_io_din <= cmd;
		i_io_clk <= 1'b1;
		wait_cycles(2);
		i_io_clk <= 1'b0;
		wait_cycles(2);
		i_io_din <= data;
		i_io_clk <= 1'b1;
		wait_cycles(2);
		i_io_clk <= 1'b0;
		wait_cycles(2);
		i_io_uio <= 1'b0;
		wait_cycles(2);
	endtask

	// Outputs trail the driven sync position by four edges
	task automatic sample_sync(input int pos, output logic hs, output logic vs);
		int target;
		int n;
		target = (pos + 4) % (4 * sync_p);
		n = 0;
		@(posedge clk_sys);
		while (vpos != target) begin
			if (n > 8 * sync_p)
				abort_run("Timed out waiting for a sync sample point");
			n++;
			@(posedge clk_sys);
		end
		hs = o_vga_hs;
		vs = o_vga_vs;
	endtask

	initial begin
		int          fd;
		int          rc;
		int          test;
		int          nw;
		int          slow;
		int          shigh;
		int          line_no;
		int          err_before;
		string       line;
		logic [15:0] w [4];
		logic [15:0] cl, cr, ll, lr, sg, mx, el, er, eh, ev;
		logic [2:0]  hs_pat;
		logic [2:0]  vs_pat;

		clk_sys = 1'b0;
		resetd = 1'b1;
		i_io_uio = 1'b0;
		i_io_clk = 1'b0;
		i_io_din = '0;
		i_core_l = '0;
		i_core_r = '0;
		i_linux_l = '0;
		i_linux_r = '0;
		i_audio_signed = 1'b1;
		i_audio_mix = MIX_NONE;
		i_hs = 1'b0;
		i_vs = 1'b0;
		line_no = 0;
		wait_cycles(2);
		resetd <= 1'b0;
		@(posedge clk_sys);
		check_value("reset left", o_audio_l, 16'h0);
		check_value("reset right", o_audio_r, 16'h0);
		check_value("reset hs", {15'h0, o_vga_hs}, 16'h1);
		check_value("reset vs", {15'h0, o_vga_vs}, 16'h1);

		fd = $fopen("dv/sys_core_golden.txt", "r");
		if (fd == 0)
			abort_run("Could not open the golden vector file");
		while ($fgets(line, fd) != 0) begin
			if (line.len() < 4 || line.getc(0) == "#")
				continue;
			rc = $sscanf(line, "%d %d %h %h %h %h %h %h %h %h %h %h %d %d %h %h %h %h",
				test, nw, w[0], w[1], w[2], w[3], cl, cr, ll, lr, sg, mx,
				slow, shigh, el, er, eh, ev);
			if (rc != 18)
				abort_run("Malformed line in the golden vector file");
			line_no++;
			err_before = errors;
			for (int i = 0; i + 1 < nw; i += 2)
				send_pair(w[i], w[i+1]);
			i_core_l <= cl;
			i_core_r <= cr;
			i_linux_l <= ll;
			i_linux_r <= lr;
			i_audio_signed <= sg[0];
			i_audio_mix <= mix_mode_t'(mx[1:0]);
			wait_cycles(20);
			// Short core glitch that the stabiliser has to reject
			i_core_l <= random_bits(16);
			i_core_r <= random_bits(16);
			wait_cycles(1 + int'(random_bits(1)));
			i_core_l <= cl;
			i_core_r <= cr;
			// Outputs hold their value through the glitch and after it
			for (int i = 0; i < 20; i++) begin
				@(posedge clk_sys);
				check_value("left", o_audio_l, el);
				check_value("right", o_audio_r, er);
			end
			if (slow == 0) begin
				check_value("hs idle", {15'h0, o_vga_hs}, eh);
				check_value("vs idle", {15'h0, o_vga_vs}, ev);
			end else begin
				sync_l = slow;
				sync_p = slow + shigh;
				sync_on = 1'b1;
				wait_cycles(64 + 8 * sync_p);
				sample_sync(2 * sync_p + slow / 2 - 1, hs_pat[2], vs_pat[2]);
				sample_sync(slow + shigh / 2, hs_pat[1], vs_pat[1]);
				sample_sync(sync_p + slow / 2 - 1, hs_pat[0], vs_pat[0]);
				check_value("hs pattern", {13'h0, hs_pat}, eh);
				check_value("vs pattern", {13'h0, vs_pat}, ev);
			end
			$display("test %0d line %0d: %s", test, line_no,
				(errors == err_before) ? "pass" : "fail");
		end
		$fclose(fd);

		$display("lines %0d, checks %0d, errors %0d", line_no, checks, errors);
		if (errors == 0 && line_no > 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

//--- hw/audio_mix_channel.sv
`timescale 1ns/1ps

module audio_mix_channel (
	input  logic                    clk_sys,
	input  logic                    resetd,
	input  sys_core_pkg::sample_t   i_core,
	input  sys_core_pkg::sample_t   i_linux,
	input  sys_core_pkg::sample_t   i_pre,
	input  logic                    i_signed,
	input  sys_core_pkg::mix_mode_t i_mix,
	input  sys_core_pkg::att_t      i_att,
	output sys_core_pkg::sample_t   o_pre,
	output sys_core_pkg::sample_t   o_sample
);
	import sys_core_pkg::*;

	sample_t     core_d1;
	sample_t     core_d2;
	sample_t     core_ok;
	sample_t     pre_d1;
	sample_ext_t core_term;
	sample_ext_t pre_mix;
	sample_ext_t mixed;
	sample_ext_t attn;
	sample_ext_t other;

	assign other = sample_ext_t'(pre_d1);

	//////////////////////////////
	// Stabiliser and pipeline
	//////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			core_d1   <= '0;
			core_d2   <= '0;
			core_ok   <= '0;
			pre_d1    <= '0;
			core_term <= '0;
			pre_mix   <= '0;
			o_pre     <= '0;
			mixed     <= '0;
			attn      <= '0;
			o_sample  <= '0;
		end else begin
			core_d1 <= i_core;
			core_d2 <= core_d1;
			// Three equal samples in a row before the core value is taken
			if (i_core == core_d1 && core_d1 == core_d2)
				core_ok <= core_d2;

			// Unsigned core audio is halved to fit beside a signed source
			core_term <= i_signed ? sample_ext_t'(core_ok) : {2'b00, core_ok[15:1]};
			pre_mix   <= core_term + sample_ext_t'(i_linux);
			o_pre     <= pre_mix[16:1];
			pre_d1    <= i_pre;

			case (i_mix)
				MIX_EIGHTH:  mixed <= pre_mix - (pre_mix >>> 3) + (other >>> 2);
				MIX_QUARTER: mixed <= pre_mix - (pre_mix >>> 2) + (other >>> 1);
				MIX_HALF:    mixed <= (pre_mix >>> 1) + other;
				default:     mixed <= pre_mix;
			endcase

			if (i_att[4])
				attn <= '0;
			else
				attn <= mixed >>> i_att[3:0];

			// Saturate to the 16-bit range
			if (attn[16] != attn[15])
				o_sample <= {attn[16], {15{~attn[16]}}};
			else
				o_sample <= attn[15:0];
		end
	end

endmodule

//--- hw/hps_cmd_decoder.sv
`timescale 1ns/1ps

module hps_cmd_decoder (
	input  logic                   clk_sys,
	input  logic                   resetd,
	input  logic                   i_io_uio,
	input  logic                   i_io_clk,
	input  sys_core_pkg::io_word_t i_io_din,
	output sys_core_pkg::att_t     o_vol_att,
	output logic                   o_csync
);
	import sys_core_pkg::*;

	logic     io_clk_d1;
	logic     io_clk_d2;
	logic     io_uio_d1;
	io_word_t io_din_d1;
	logic     strobe;
	logic     has_cmd;
	cmd_t     cmd;
	io_word_t cfg;
	att_t     vol_att;

	// Host levels sampled once, edge found on the sampled copy
	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			io_clk_d1 <= 1'b0;
			io_clk_d2 <= 1'b0;
			io_uio_d1 <= 1'b0;
		end else begin
			io_clk_d1 <= i_io_clk;
			io_clk_d2 <= io_clk_d1;
			io_uio_d1 <= i_io_uio;
		end
	end

	// Data word kept aligned with the sampled strobe
	always_ff @(posedge clk_sys) begin
		io_din_d1 <= i_io_din;
	end

	assign strobe = io_clk_d1 & ~io_clk_d2;

	// First word is the command, the rest is its data
	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			has_cmd <= 1'b0;
			cmd     <= '0;
			cfg     <= '0;
			vol_att <= '0;
		end else if (!io_uio_d1) begin
			has_cmd <= 1'b0;
		end else if (strobe) begin
			if (!has_cmd) begin
				has_cmd <= 1'b1;
				cmd     <= io_din_d1[7:0];
			end else begin
				case (cmd)
					CMD_CFG:     cfg <= io_din_d1;
					CMD_VOL_ATT: vol_att <= io_din_d1[4:0];
					// Unknown commands swallow their data
					default: ;
				endcase
			end
		end
	end

	assign o_vol_att = vol_att;
	assign o_csync   = cfg[CFG_CSYNC_BIT];

endmodule

//--- hw/sync_polarity_fix.sv
`timescale 1ns/1ps

module sync_polarity_fix #(
	parameter int SYNC_CNT_W = 12
) (
	input  logic clk_sys,
	input  logic resetd,
	input  logic i_sync,
	output logic o_sync
);

	logic                  sync_d1;
	logic                  sync_d2;
	logic [SYNC_CNT_W-1:0] cnt;
	logic [SYNC_CNT_W-1:0] len_high;
	logic [SYNC_CNT_W-1:0] len_low;
	logic                  pol;

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			sync_d1  <= 1'b0;
			sync_d2  <= 1'b0;
			cnt      <= '0;
			len_high <= '0;
			len_low  <= '0;
			pol      <= 1'b0;
		end else begin
			sync_d1 <= i_sync;
			sync_d2 <= sync_d1;

			// Rising edge closes a low phase, falling edge a high one
			if (sync_d1 && !sync_d2)
				len_low <= cnt;
			if (!sync_d1 && sync_d2)
				len_high <= cnt;

			if (sync_d1 != sync_d2)
				cnt <= '0;
			else if (cnt != '1)
				cnt <= cnt + 1'b1;

			// Pulse is the shorter phase
			pol <= (len_high > len_low);
		end
	end

	assign o_sync = sync_d2 ^ pol;

endmodule

//--- hw/sys_core_pkg.sv
package sys_core_pkg;

	//////////////////////////////
	// Audio types
	//////////////////////////////

	// 16-bit signed sample as seen on the ports
	typedef logic signed [15:0] sample_t;

	// Internal sum, one bit of headroom
	typedef logic signed [16:0] sample_ext_t;

	// Bit 4 mutes, bits 3..0 shift right
	typedef logic [4:0] att_t;

	// Cross-feed amount between left and right
	typedef enum logic [1:0] {
		MIX_NONE    = 2'd0,
		MIX_EIGHTH  = 2'd1,
		MIX_QUARTER = 2'd2,
		MIX_HALF    = 2'd3
	} mix_mode_t;

	//////////////////////////////
	// Host port types
	//////////////////////////////

	// One host data word
	typedef logic [15:0] io_word_t;

	// Command code, low byte of the first word
	typedef logic [7:0] cmd_t;

	// Configuration word
	localparam cmd_t CMD_CFG = 8'h01;

	// Volume attenuation, low five bits used
	localparam cmd_t CMD_VOL_ATT = 8'h26;

	// Composite sync enable inside the configuration word
	localparam int CFG_CSYNC_BIT = 3;

endpackage

//--- hw/sys_core_top.sv
`timescale 1ns/1ps

module sys_core_top #(
	parameter int SYNC_CNT_W = 12
) (
	input  logic                    clk_sys,
	input  logic                    resetd,
	input  logic                    i_io_uio,
	input  logic                    i_io_clk,
	input  sys_core_pkg::io_word_t  i_io_din,
	input  sys_core_pkg::sample_t   i_core_l,
	input  sys_core_pkg::sample_t   i_core_r,
	input  sys_core_pkg::sample_t   i_linux_l,
	input  sys_core_pkg::sample_t   i_linux_r,
	input  logic                    i_audio_signed,
	input  sys_core_pkg::mix_mode_t i_audio_mix,
	input  logic                    i_hs,
	input  logic                    i_vs,
	output sys_core_pkg::sample_t   o_audio_l,
	output sys_core_pkg::sample_t   o_audio_r,
	output logic                    o_vga_hs,
	output logic                    o_vga_vs
);
	import sys_core_pkg::*;

	att_t    vol_att;
	logic    csync;
	sample_t pre_l;
	sample_t pre_r;

	hps_cmd_decoder u_decoder (
		.clk_sys   (clk_sys),
		.resetd    (resetd),
		.i_io_uio  (i_io_uio),
		.i_io_clk  (i_io_clk),
		.i_io_din  (i_io_din),
		.o_vol_att (vol_att),
		.o_csync   (csync)
	);

	// Left and right each take the other's halved pre-mix
	audio_mix_channel u_mix_l (
		.clk_sys  (clk_sys),
		.resetd   (resetd),
		.i_core   (i_core_l),
		.i_linux  (i_linux_l),
		.i_pre    (pre_r),
		.i_signed (i_audio_signed),
		.i_mix    (i_audio_mix),
		.i_att    (vol_att),
		.o_pre    (pre_l),
		.o_sample (o_audio_l)
	);

	audio_mix_channel u_mix_r (
		.clk_sys  (clk_sys),
		.resetd   (resetd),
		.i_core   (i_core_r),
		.i_linux  (i_linux_r),
		.i_pre    (pre_l),
		.i_signed (i_audio_signed),
		.i_mix    (i_audio_mix),
		.i_att    (vol_att),
		.o_pre    (pre_r),
		.o_sample (o_audio_r)
	);

	video_sync_out #(
		.SYNC_CNT_W(SYNC_CNT_W)
	) u_sync_out (
		.clk_sys  (clk_sys),
		.resetd   (resetd),
		.i_hs     (i_hs),
		.i_vs     (i_vs),
		.i_csync  (csync),
		.o_vga_hs (o_vga_hs),
		.o_vga_vs (o_vga_vs)
	);

endmodule

//--- hw/video_sync_out.sv
`timescale 1ns/1ps

module video_sync_out #(
	parameter int SYNC_CNT_W = 12
) (
	input  logic clk_sys,
	input  logic resetd,
	input  logic i_hs,
	input  logic i_vs,
	input  logic i_csync,
	output logic o_vga_hs,
	output logic o_vga_vs
);

	logic hs_norm;
	logic vs_norm;

	sync_polarity_fix #(
		.SYNC_CNT_W(SYNC_CNT_W)
	) u_fix_hs (
		.clk_sys (clk_sys),
		.resetd  (resetd),
		.i_sync  (i_hs),
		.o_sync  (hs_norm)
	);

	sync_polarity_fix #(
		.SYNC_CNT_W(SYNC_CNT_W)
	) u_fix_vs (
		.clk_sys (clk_sys),
		.resetd  (resetd),
		.i_sync  (i_vs),
		.o_sync  (vs_norm)
	);

	// VGA wants active-low sync, composite carries both on HS
	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			o_vga_hs <= 1'b1;
			o_vga_vs <= 1'b1;
		end else if (i_csync) begin
			o_vga_hs <= ~(hs_norm ^ vs_norm);
			o_vga_vs <= 1'b1;
		end else begin
			o_vga_hs <= ~hs_norm;
			o_vga_vs <= ~vs_norm;
		end
	end

endmodule
